/* verilog/eth_pkg.sv */
`default_nettype none

package eth_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;
    typedef logic [10:0] len_t;

    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    // Non-reflected register value left by a good frame with its own FCS.
    localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_LEN = 7;
    localparam int GAP_LEN      = 12;

endpackage

`default_nettype wire

/* verilog/crc32.sv */
`timescale 1ns/100ps
`default_nettype none

module crc32 (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           enable,
    input  wire eth_pkg::byte_t din,
    output eth_pkg::crc_t       dout
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_WAIT,
        ST_WORK,
        ST_HOLD0,
        ST_HOLD1,
        ST_HOLD2,
        ST_HOLD3,
        ST_HOLD4,
        ST_HOLD5,
        ST_DONE
    } crc_state_t;

    crc_state_t    state;
    crc_state_t    state_nxt;
    eth_pkg::crc_t crc_q;
    eth_pkg::crc_t base;
    eth_pkg::crc_t nxt;
    logic [7:0]    x;

    assign base = (state == ST_WAIT) ? eth_pkg::CRC_INIT : crc_q; // first byte folds into the preset.

    // din[0] goes on the wire first, so it meets the top register bit.
    for (genvar i = 0; i < 8; i++) begin : g_fold
        assign x[i] = base[24 + i] ^ din[7 - i];
    end

    assign nxt[0]  = x[0] ^ x[6];
    assign nxt[1]  = x[0] ^ x[1] ^ x[6] ^ x[7];
    assign nxt[2]  = x[0] ^ x[1] ^ x[2] ^ x[6] ^ x[7];
    assign nxt[3]  = x[1] ^ x[2] ^ x[3] ^ x[7];
    assign nxt[4]  = x[0] ^ x[2] ^ x[3] ^ x[4] ^ x[6];
    assign nxt[5]  = x[0] ^ x[1] ^ x[3] ^ x[4] ^ x[5] ^ x[6] ^ x[7];
    assign nxt[6]  = x[1] ^ x[2] ^ x[4] ^ x[5] ^ x[6] ^ x[7];
    assign nxt[7]  = x[0] ^ x[2] ^ x[3] ^ x[5] ^ x[7];
    assign nxt[8]  = base[0] ^ x[0] ^ x[1] ^ x[3] ^ x[4];
    assign nxt[9]  = base[1] ^ x[1] ^ x[2] ^ x[4] ^ x[5];
    assign nxt[10] = base[2] ^ x[0] ^ x[2] ^ x[3] ^ x[5];
    assign nxt[11] = base[3] ^ x[0] ^ x[1] ^ x[3] ^ x[4];
    assign nxt[12] = base[4] ^ x[0] ^ x[1] ^ x[2] ^ x[4] ^ x[5] ^ x[6];
    assign nxt[13] = base[5] ^ x[1] ^ x[2] ^ x[3] ^ x[5] ^ x[6] ^ x[7];
    assign nxt[14] = base[6] ^ x[2] ^ x[3] ^ x[4] ^ x[6] ^ x[7];
    assign nxt[15] = base[7] ^ x[3] ^ x[4] ^ x[5] ^ x[7];
    assign nxt[16] = base[8] ^ x[0] ^ x[4] ^ x[5];
    assign nxt[17] = base[9] ^ x[1] ^ x[5] ^ x[6];
    assign nxt[18] = base[10] ^ x[2] ^ x[6] ^ x[7];
    assign nxt[19] = base[11] ^ x[3] ^ x[7];
    assign nxt[20] = base[12] ^ x[4];
    assign nxt[21] = base[13] ^ x[5];
    assign nxt[22] = base[14] ^ x[0];
    assign nxt[23] = base[15] ^ x[0] ^ x[1] ^ x[6];
    assign nxt[24] = base[16] ^ x[1] ^ x[2] ^ x[7];
    assign nxt[25] = base[17] ^ x[2] ^ x[3];
    assign nxt[26] = base[18] ^ x[0] ^ x[3] ^ x[4] ^ x[6];
    assign nxt[27] = base[19] ^ x[1] ^ x[4] ^ x[5] ^ x[7];
    assign nxt[28] = base[20] ^ x[2] ^ x[5] ^ x[6];
    assign nxt[29] = base[21] ^ x[3] ^ x[6] ^ x[7];
    assign nxt[30] = base[22] ^ x[4] ^ x[7];
    assign nxt[31] = base[23] ^ x[5];

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  state_nxt = ST_WAIT;
            ST_WAIT:  if (enable) state_nxt = ST_WORK;
            ST_WORK:  if (!enable) state_nxt = ST_HOLD0;
            ST_HOLD0: state_nxt = ST_HOLD1;
            ST_HOLD1: state_nxt = ST_HOLD2;
            ST_HOLD2: state_nxt = ST_HOLD3;
            ST_HOLD3: state_nxt = ST_HOLD4;
            ST_HOLD4: state_nxt = ST_HOLD5;
            ST_HOLD5: state_nxt = ST_DONE;
            ST_DONE:  state_nxt = ST_WAIT;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state == ST_IDLE) begin
            crc_q <= eth_pkg::CRC_INIT;
        end else if ((state == ST_WAIT || state == ST_WORK) && enable) begin
            crc_q <= nxt;
        end else if (state == ST_WAIT) begin
            crc_q <= eth_pkg::CRC_INIT;
        end
    end

    assign dout = crc_q; // held through the hold states for the FCS readout.

endmodule

`default_nettype wire

/* verilog/byte_delay.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_delay #(
    parameter int DEPTH = 8
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire eth_pkg::byte_t din,
    input  wire logic           din_valid,
    output eth_pkg::byte_t      dout,
    output logic                dout_valid
);

    eth_pkg::byte_t   data_sr [DEPTH];
    logic [DEPTH-1:0] valid_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[DEPTH-2:0], din_valid};
        end
    end

    always_ff @(posedge clk) begin
        data_sr[0] <= din;
        for (int i = 1; i < DEPTH; i++) begin
            data_sr[i] <= data_sr[i - 1];
        end
    end

    assign dout       = data_sr[DEPTH-1];
    assign dout_valid = valid_sr[DEPTH-1];

endmodule

`default_nettype wire

/* verilog/eth_tx_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_tx_framer (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           tx_valid,
    input  wire eth_pkg::byte_t pay_data,
    input  wire logic           pay_valid,
    input  wire eth_pkg::crc_t  fcs,
    output eth_pkg::byte_t      txo_data,
    output logic                txo_valid,
    output logic                tx_busy,
    output logic                crc_en,
    output eth_pkg::byte_t      crc_din
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PRE,
        TX_PAY,
        TX_FCS,
        TX_GAP
    } tx_state_t;

    tx_state_t     state;
    logic [2:0]    byte_cnt;
    logic [3:0]    gap_cnt;
    eth_pkg::crc_t fcs_wire;

    // Complemented register, bit reversed so each byte goes out LSB first.
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            fcs_wire[i] = ~fcs[31 - i];
        end
    end

    assign crc_en  = (state == TX_PAY) && pay_valid;
    assign crc_din = pay_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_IDLE;
            byte_cnt  <= '0;
            gap_cnt   <= '0;
            txo_valid <= 1'b0;
            tx_busy   <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_valid) begin
                        state     <= TX_PRE;
                        byte_cnt  <= 3'd1;     // first preamble byte leaves now.
                        txo_valid <= 1'b1;
                        tx_busy   <= 1'b1;
                    end
                end
                TX_PRE: begin
                    if (byte_cnt == 3'(eth_pkg::PREAMBLE_LEN)) begin
                        state <= TX_PAY;       // delimiter leaves on this edge.
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                TX_PAY: begin
                    if (!pay_valid) begin
                        state    <= TX_FCS;
                        byte_cnt <= 3'd1;
                    end
                end
                TX_FCS: begin
                    if (byte_cnt == 3'd3) begin
                        state   <= TX_GAP;
                        gap_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                TX_GAP: begin
                    txo_valid <= 1'b0;
                    if (gap_cnt == 4'(eth_pkg::GAP_LEN)) begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;
                    end else begin
                        gap_cnt <= gap_cnt + 4'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            TX_IDLE: txo_data <= eth_pkg::PREAMBLE_BYTE;
            TX_PRE: begin
                if (byte_cnt == 3'(eth_pkg::PREAMBLE_LEN)) begin
                    txo_data <= eth_pkg::SFD_BYTE;
                end else begin
                    txo_data <= eth_pkg::PREAMBLE_BYTE;
                end
            end
            TX_PAY:  txo_data <= pay_valid ? pay_data : fcs_wire[7:0];
            TX_FCS:  txo_data <= fcs_wire[8*byte_cnt[1:0] +: 8];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/eth_rx_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_checker (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire eth_pkg::byte_t rxi_data,
    input  wire logic           rxi_valid,
    input  wire eth_pkg::crc_t  crc,
    output logic                crc_en,
    output eth_pkg::byte_t      crc_din,
    output logic                rx_good,
    output logic                rx_bad,
    output eth_pkg::len_t       rx_len
);

    typedef enum logic [1:0] {
        RX_HUNT,
        RX_BODY,
        RX_VERDICT
    } rx_state_t;

    rx_state_t     state;
    logic          valid_q;
    logic          skip;
    logic          sfd_seen;
    eth_pkg::len_t len_cnt;

    assign crc_en  = (state == RX_BODY) && rxi_valid;
    assign crc_din = rxi_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_HUNT;
            valid_q  <= 1'b0;
            skip     <= 1'b0;
            sfd_seen <= 1'b0;
            len_cnt  <= '0;
            rx_good  <= 1'b0;
            rx_bad   <= 1'b0;
        end else begin
            valid_q <= rxi_valid;
            rx_good <= 1'b0;
            rx_bad  <= 1'b0;
            case (state)
                RX_HUNT: begin
                    if (rxi_valid && !skip && rxi_data == eth_pkg::SFD_BYTE) begin
                        state    <= RX_BODY;
                        sfd_seen <= 1'b1;
                        len_cnt  <= '0;
                    end else if (rxi_valid && rxi_data != eth_pkg::PREAMBLE_BYTE) begin
                        skip <= 1'b1;          // no delimiter can follow a stray byte.
                    end else if (!rxi_valid && valid_q) begin
                        state <= RX_VERDICT;
                    end
                end
                RX_BODY: begin
                    if (rxi_valid) begin
                        len_cnt <= len_cnt + 11'd1;
                    end else begin
                        state <= RX_VERDICT;   // the last CRC update landed on the previous edge.
                    end
                end
                RX_VERDICT: begin
                    state    <= RX_HUNT;
                    skip     <= 1'b0;
                    sfd_seen <= 1'b0;
                    if (sfd_seen && crc == eth_pkg::CRC_RESIDUE) begin
                        rx_good <= 1'b1;
                    end else begin
                        rx_bad <= 1'b1;
                    end
                end
                default: state <= RX_HUNT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_VERDICT) begin
            rx_len <= sfd_seen ? len_cnt : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/eth_fcs_core.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_fcs_core (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire eth_pkg::byte_t tx_data,
    input  wire logic           tx_valid,
    input  wire eth_pkg::byte_t rxi_data,
    input  wire logic           rxi_valid,
    output wire eth_pkg::byte_t txo_data,
    output wire logic           txo_valid,
    output wire logic           tx_busy,
    output wire logic           rx_good,
    output wire logic           rx_bad,
    output wire eth_pkg::len_t  rx_len
);

    localparam int PRE_DELAY = eth_pkg::PREAMBLE_LEN + 1; // preamble plus delimiter.

    eth_pkg::byte_t pay_data;
    logic           pay_valid;
    eth_pkg::crc_t  tx_fcs;
    logic           tx_crc_en;
    eth_pkg::byte_t tx_crc_din;
    eth_pkg::crc_t  rx_crc;
    logic           rx_crc_en;
    eth_pkg::byte_t rx_crc_din;

    byte_delay #(
        .DEPTH(PRE_DELAY)
    ) u_delay (
        .clk       (clk),
        .rst       (rst),
        .din       (tx_data),
        .din_valid (tx_valid),
        .dout      (pay_data),
        .dout_valid(pay_valid)
    );

    eth_tx_framer u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_valid (tx_valid),
        .pay_data (pay_data),
        .pay_valid(pay_valid),
        .fcs      (tx_fcs),
        .txo_data (txo_data),
        .txo_valid(txo_valid),
        .tx_busy  (tx_busy),
        .crc_en   (tx_crc_en),
        .crc_din  (tx_crc_din)
    );

    crc32 u_tx_crc (
        .clk   (clk),
        .rst   (rst),
        .enable(tx_crc_en),
        .din   (tx_crc_din),
        .dout  (tx_fcs)
    );

    eth_rx_checker u_rx (
        .clk      (clk),
        .rst      (rst),
        .rxi_data (rxi_data),
        .rxi_valid(rxi_valid),
        .crc      (rx_crc),
        .crc_en   (rx_crc_en),
        .crc_din  (rx_crc_din),
        .rx_good  (rx_good),
        .rx_bad   (rx_bad),
        .rx_len   (rx_len)
    );

    crc32 u_rx_crc (
        .clk   (clk),
        .rst   (rst),
        .enable(rx_crc_en),
        .din   (rx_crc_din),
        .dout  (rx_crc)
    );

endmodule

`default_nettype wire

/* include/eth_tb_util.svh */
`ifndef ETH_TB_UTIL_SVH
`define ETH_TB_UTIL_SVH

// next state of the 32-bit linear congruential generator.
function automatic logic [31:0] lcg_next(input logic [31:0] seed);
    return seed * 32'd1664525 + 32'd1013904223;
endfunction

// the middle bits of the state make a better byte than the low ones.
function automatic eth_pkg::byte_t lcg_byte(input logic [31:0] seed);
    return seed[23:16];
endfunction

// one byte of the reflected CRC-32, bit by bit. Complement the result for the FCS.
function automatic eth_pkg::crc_t ref_crc_byte(input eth_pkg::crc_t crc,
                                               input eth_pkg::byte_t b);
    eth_pkg::crc_t c;
    c = crc ^ {24'd0, b};
    for (int i = 0; i < 8; i++) begin
        if (c[0]) begin
            c = (c >> 1) ^ 32'hEDB8_8320;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

`endif

/* tests/eth_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_tb;

    `include "eth_tb_util.svh"

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 9;

    // Frame table. Output byte 7 is the delimiter and the payload starts at byte 8.
    // row_rx_len of -1 leaves rx_len unchecked.
    int             row_len     [NUM_ROWS] = '{1, 2, 4, 46, 64, 64, 46, 1, 2};
    bit             row_corrupt [NUM_ROWS] = '{0, 0, 1, 0, 1, 0, 1, 0, 0};
    int             row_idx     [NUM_ROWS] = '{0, 0, 9, 0, 7, 0, 56, 0, 0};
    eth_pkg::byte_t row_mask    [NUM_ROWS] = '{8'h00, 8'h00, 8'h01, 8'h00, 8'h10,
                                               8'h00, 8'h40, 8'h00, 8'h00};
    bit             row_good    [NUM_ROWS] = '{1, 1, 0, 1, 0, 1, 0, 1, 1};
    int             row_rx_len  [NUM_ROWS] = '{5, 6, -1, 50, 0, 68, -1, 5, 6};

    logic           clk = 1'b0;
    logic           rst;
    eth_pkg::byte_t tx_data;
    logic           tx_valid;
    eth_pkg::byte_t rxi_data;
    logic           rxi_valid;
    eth_pkg::byte_t txo_data;
    logic           txo_valid;
    logic           tx_busy;
    logic           rx_good;
    logic           rx_bad;
    eth_pkg::len_t  rx_len;

    int             cyc;
    int             start_cyc;
    int             first_cyc;
    int             fall_cyc;
    int             busy_low_cyc;
    int             good_cnt;
    int             bad_cnt;
    int             pulse_cyc;
    int             pulse_len;
    logic           txo_prev = 1'b0;
    eth_pkg::byte_t out_q [$];
    int             out_idx;
    bit             cur_corrupt;
    int             cur_idx;
    eth_pkg::byte_t cur_mask;
    logic [31:0]    rng;
    int             errors;

    eth_fcs_core u_dut (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .rxi_data (rxi_data),
        .rxi_valid(rxi_valid),
        .txo_data (txo_data),
        .txo_valid(txo_valid),
        .tx_busy  (tx_busy),
        .rx_good  (rx_good),
        .rx_bad   (rx_bad),
        .rx_len   (rx_len)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // loopback with a single corrupted byte per frame.
    assign rxi_valid = txo_valid;
    assign rxi_data  = txo_data ^ ((cur_corrupt && out_idx == cur_idx) ? cur_mask : 8'h00);

    always @(posedge clk) begin
        if (rst || !txo_valid) begin
            out_idx <= 0;
        end else begin
            out_idx <= out_idx + 1; // index of the byte now on txo_data.
        end
    end

    // Sees the values of the cycle that ends at this edge.
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst) begin
            if (tx_valid && !tx_busy && start_cyc < 0) begin
                start_cyc = cyc;
            end
            if (txo_valid) begin
                if (!txo_prev) begin
                    first_cyc = cyc;
                end
                out_q.push_back(txo_data);
            end else if (txo_prev) begin
                fall_cyc = cyc;
            end
            if (fall_cyc >= 0 && busy_low_cyc < 0 && !tx_busy) begin
                busy_low_cyc = cyc;
            end
            if (rx_good || rx_bad) begin
                good_cnt  = good_cnt + (rx_good ? 1 : 0);
                bad_cnt   = bad_cnt + (rx_bad ? 1 : 0);
                pulse_cyc = cyc;
                pulse_len = rx_len;
            end
            txo_prev = txo_valid;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic clear_monitor();
        start_cyc    = -1;
        first_cyc    = -1;
        fall_cyc     = -1;
        busy_low_cyc = -1;
        good_cnt     = 0;
        bad_cnt      = 0;
        pulse_cyc    = -1;
        pulse_len    = -1;
        out_q.delete();
    endtask

    task automatic send_row(input int r);
        eth_pkg::byte_t payload [$];
        eth_pkg::byte_t exp_q   [$];
        eth_pkg::crc_t  crc;
        eth_pkg::crc_t  fcs;
        crc = 32'hFFFF_FFFF;
        for (int k = 0; k < row_len[r]; k++) begin
            rng = lcg_next(rng);
            payload.push_back(lcg_byte(rng));
            crc = ref_crc_byte(crc, payload[k]);
        end
        fcs = ~crc;
        for (int k = 0; k < 7; k++) begin
            exp_q.push_back(8'h55);
        end
        exp_q.push_back(8'hD5);
        foreach (payload[k]) begin
            exp_q.push_back(payload[k]);
        end
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(fcs[8*k +: 8]); // low byte first.
        end

        while (tx_busy) begin
            @(posedge clk);
            #1;
        end
        clear_monitor();
        cur_corrupt = row_corrupt[r];
        cur_idx     = row_idx[r];
        cur_mask    = row_mask[r];
        foreach (payload[k]) begin
            tx_valid = 1'b1;
            tx_data  = payload[k];
            @(posedge clk);
            #1;
        end
        tx_valid = 1'b0;
        tx_data  = 8'h00;
        while (busy_low_cyc < 0 || good_cnt + bad_cnt == 0) begin
            @(posedge clk);
            #1;
        end

        if (first_cyc != start_cyc + 1) begin
            report_mismatch("txo_valid rise cycle", start_cyc + 1, first_cyc);
        end
        if (out_q.size() != exp_q.size()) begin
            report_mismatch("txo frame length", exp_q.size(), out_q.size());
        end else begin
            foreach (exp_q[k]) begin
                if (out_q[k] !== exp_q[k]) begin
                    report_mismatch($sformatf("txo_data[%0d]", k), exp_q[k], out_q[k]);
                end
            end
        end
        if (busy_low_cyc != fall_cyc + 12) begin
            report_mismatch("tx_busy fall cycle", fall_cyc + 12, busy_low_cyc);
        end
        if (good_cnt != (row_good[r] ? 1 : 0)) begin
            report_mismatch("rx_good pulses", row_good[r] ? 1 : 0, good_cnt);
        end
        if (bad_cnt != (row_good[r] ? 0 : 1)) begin
            report_mismatch("rx_bad pulses", row_good[r] ? 0 : 1, bad_cnt);
        end
        if (pulse_cyc != fall_cyc + 2) begin
            report_mismatch("verdict pulse cycle", fall_cyc + 2, pulse_cyc);
        end
        if (row_rx_len[r] >= 0 && pulse_len != row_rx_len[r]) begin
            report_mismatch("rx_len", row_rx_len[r], pulse_len);
        end
    endtask

    initial begin
        #((NUM_ROWS * 200 + 50) * CLK_PERIOD);
        $display("timeout: the frames did not complete in the allowed number of cycles");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        tx_valid    = 1'b0;
        tx_data     = 8'h00;
        cur_corrupt = 1'b0;
        cur_idx     = 0;
        cur_mask    = 8'h00;
        rng         = 32'd16;
        errors      = 0;
        clear_monitor();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (txo_valid !== 1'b0 || tx_busy !== 1'b0) begin
            report_mismatch("txo_valid/tx_busy after reset", 0, {txo_valid, tx_busy});
        end
        if (rx_good !== 1'b0 || rx_bad !== 1'b0) begin
            report_mismatch("rx_good/rx_bad after reset", 0, {rx_good, rx_bad});
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_row(r); // rows run back to back as soon as tx_busy drops.
        end
        $display("eth_tb: %0d errors over %0d frames", errors, NUM_ROWS);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
verilog/eth_pkg.sv
verilog/crc32.sv
verilog/byte_delay.sv
verilog/eth_tx_framer.sv
verilog/eth_rx_checker.sv
verilog/eth_fcs_core.sv
tests/eth_tb.sv
